//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_b_channel_xbar
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
verilog/axi_pkg.sv
verilog/xbar_pkg.sv
verilog/b_resp_arbiter.sv
verilog/b_resp_router.sv
verilog/b_channel_xbar.sv
sim/b_resp_arbiter_assert.sv
sim/tb_b_channel_xbar.sv

//--- sim/b_resp_arbiter_assert.sv
`timescale 1ns/1ps

module b_resp_arbiter_assert (
  input logic            clk,
  input logic            rstn,
  input axi_pkg::b_slv_t s0_b,
  input axi_pkg::b_slv_t s1_b,
  input axi_pkg::b_slv_t s2_b,
  input logic            s0_bready,
  input logic            s1_bready,
  input logic            s2_bready,
  input axi_pkg::b_slv_t arb_b,
  input logic            arb_bready
);

  // Only the locked slave can be granted
  onehot_ready: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({s2_bready, s1_bready, s0_bready}))
    else $error("more than one slave bready high");

  // Stalled response must not move
  hold_stable: assert property (@(posedge clk) disable iff (!rstn)
    arb_b.valid && !arb_bready |=> $stable(arb_b))
    else $error("arb_b changed while stalled");

  s0_ready_valid: assert property (@(posedge clk) disable iff (!rstn) s0_bready |-> s0_b.valid)
    else $error("s0_bready without s0 valid");
  s1_ready_valid: assert property (@(posedge clk) disable iff (!rstn) s1_bready |-> s1_b.valid)
    else $error("s1_bready without s1 valid");
  s2_ready_valid: assert property (@(posedge clk) disable iff (!rstn) s2_bready |-> s2_b.valid)
    else $error("s2_bready without s2 valid");

endmodule

//--- sim/tb_b_channel_xbar.sv
`timescale 1ns/1ps

module tb_b_channel_xbar;

  import axi_pkg::*;

  // Slave 0 sits in the low slice of id and resp
  typedef struct packed {
    logic [2:0]      mask;
    logic [2:0][7:0] id;
    logic [2:0][1:0] resp;
    logic [3:0]      stall0;
    logic [3:0]      stall1;
  } row_t;

  localparam int NUM_ROWS  = 8;
  localparam int ROW_LIMIT = 60;

  logic      clk;
  logic      rstn;
  b_slv_t    sb [3];
  logic      s0_bready;
  logic      s1_bready;
  logic      s2_bready;
  b_mst_t    m0_b;
  b_mst_t    m1_b;
  logic      m0_bready;
  logic      m1_bready;
  wire [2:0] s_rdy;

  row_t   rows [NUM_ROWS];
  integer seed;
  int     errors;
  int     checks;
  logic   timed_out;

  assign s_rdy = {s2_bready, s1_bready, s0_bready};

  b_channel_xbar dut0 (
    .clk       (clk),
    .rstn      (rstn),
    .s0_b      (sb[0]),
    .s1_b      (sb[1]),
    .s2_b      (sb[2]),
    .s0_bready (s0_bready),
    .s1_bready (s1_bready),
    .s2_bready (s2_bready),
    .m0_b      (m0_b),
    .m1_b      (m1_b),
    .m0_bready (m0_bready),
    .m1_bready (m1_bready)
  );

  bind b_resp_arbiter b_resp_arbiter_assert arb_chk (
    .clk        (clk),
    .rstn       (rstn),
    .s0_b       (s0_b),
    .s1_b       (s1_b),
    .s2_b       (s2_b),
    .s0_bready  (s0_bready),
    .s1_bready  (s1_bready),
    .s2_bready  (s2_bready),
    .arb_b      (arb_b),
    .arb_bready (arb_bready)
  );

  always #50 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Tags 0 and 1 name a master and 2 means nobody
  function automatic logic [1:0] dest_of(input logic [7:0] id);
    if (id[3:0] == 4'd0) begin
      return 2'd0;
    end else if (id[3:0] == 4'd1) begin
      return 2'd1;
    end
    return 2'd2;
  endfunction

  task automatic build_rows();
    integer r;
    // mask, ids (slave 2 first), resps (slave 2 first), stall m0, stall m1
    rows[0] = {3'b001, {8'h00, 8'h00, 8'h50}, {2'd0, 2'd0, 2'd0}, 4'd0, 4'd0};
    rows[1] = {3'b010, {8'h00, 8'hA1, 8'h00}, {2'd0, 2'd1, 2'd0}, 4'd0, 4'd0};
    rows[2] = {3'b100, {8'h31, 8'h00, 8'h00}, {2'd2, 2'd0, 2'd0}, 4'd0, 4'd0};
    rows[3] = {3'b111, {8'hC0, 8'h21, 8'h70}, {2'd2, 2'd3, 2'd0}, 4'd0, 4'd0};
    rows[4] = {3'b001, 24'h0, 6'h0, 4'd3, 4'd3};
    rows[5] = {3'b110, 24'h0, 6'h0, 4'd2, 4'd4};
    rows[6] = {3'b100, {8'h95, 8'h00, 8'h00}, {2'd1, 2'd0, 2'd0}, 4'd0, 4'd0};
    rows[7] = {3'b111, {8'hE1, 8'h60, 8'h1F}, {2'd0, 2'd2, 2'd3}, 4'd1, 4'd2};
    // Stall rows get random IDs tagged for a real master
    for (int k = 4; k < 6; k++) begin
      for (int i = 0; i < 3; i++) begin
        r = $random(seed);
        rows[k].id[i]   = {r[7:4], 3'b000, r[0]};
        rows[k].resp[i] = r[9:8];
      end
    end
  endtask

  task automatic run_row(input int n);
    row_t       row;
    int         q[$];
    int         h;
    int         cyc;
    int         idle;
    int         start_err;
    int         hold [2];
    logic [2:0] done;
    logic [1:0] d;
    logic       arrived;
    logic       xfer;
    logic       mrdy;
    b_mst_t     mb;
    row       = rows[n];
    start_err = errors;
    done      = '0;
    hold      = '{0, 0};
    cyc       = 0;
    idle      = 0;
    for (int i = 0; i < 3; i++) begin
      if (row.mask[i]) begin
        q.push_back(i);
      end
    end
    while (q.size() > 0 && !timed_out) begin
      @(negedge clk);
      for (int i = 0; i < 3; i++) begin
        if (cyc == 0 || done[i]) begin
          sb[i] = '0;
        end
        if (cyc == 0 && row.mask[i]) begin
          sb[i].id.raw = row.id[i];
          sb[i].resp   = bresp_e'(row.resp[i]);
          sb[i].valid  = 1'b1;
        end
      end
      m0_bready = (hold[0] >= int'(row.stall0));
      m1_bready = (hold[1] >= int'(row.stall1));
      #10;
      h    = q[0];
      d    = dest_of(row.id[h]);
      xfer = 1'b0;
      for (int i = 0; i < 3; i++) begin
        if (i != h) begin
          check($sformatf("s%0d_bready", i), 32'(s_rdy[i]), 32'd0);
        end
      end
      if (d == 2'd2) begin
        check("m0_b.valid", 32'(m0_b.valid), 32'd0);
        check("m1_b.valid", 32'(m1_b.valid), 32'd0);
        arrived = s_rdy[h];
        xfer    = s_rdy[h];
      end else begin
        mb   = d[0] ? m1_b : m0_b;
        mrdy = d[0] ? m1_bready : m0_bready;
        check($sformatf("m%0d_b.valid", 1 - d[0]),
              32'(d[0] ? m0_b.valid : m1_b.valid), 32'd0);
        if (mb.valid) begin
          check($sformatf("m%0d_b.id", d[0]), 32'(mb.id), 32'(row.id[h][7:4]));
          check($sformatf("m%0d_b.resp", d[0]), 32'(mb.resp), 32'(row.resp[h]));
          check($sformatf("s%0d_bready", h), 32'(s_rdy[h]), 32'(mrdy));
          hold[d[0]] = mrdy ? 0 : hold[d[0]] + 1;
        end else begin
          check($sformatf("s%0d_bready", h), 32'(s_rdy[h]), 32'd0);
        end
        arrived = mb.valid;
        xfer    = mb.valid && mrdy && s_rdy[h];
      end
      // First response shows one cycle after valid when the arbiter starts idle
      if (cyc == 1 && q.size() == $countones(row.mask)) begin
        check(d == 2'd2 ? $sformatf("s%0d_bready", h) : $sformatf("m%0d_b.valid", d[0]),
              32'(arrived), 32'd1);
      end
      if (xfer) begin
        void'(q.pop_front());
        done[h] = 1'b1;
        idle    = 0;
      end
      cyc++;
      idle++;
      if (idle > ROW_LIMIT) begin
        timed_out = 1'b1;
        $display("Timeout: row %0d made no progress for %0d cycles", n, ROW_LIMIT);
      end
    end
    $display("Row %0d: %0d responses, %0d errors", n, $countones(row.mask), errors - start_err);
  endtask

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    m0_bready = 1'b0;
    m1_bready = 1'b0;
    for (int i = 0; i < 3; i++) begin
      sb[i] = '0;
    end
    seed      = 32'hdc2a_f29a;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    build_rows();
    repeat (8) @(posedge clk);
    @(negedge clk);
    check("slave bready in reset", 32'(s_rdy), 32'd0);
    check("m0_b.valid in reset", 32'(m0_b.valid), 32'd0);
    check("m1_b.valid in reset", 32'(m1_b.valid), 32'd0);
    rstn = 1'b1;
    #10;
    check("m0_b", 32'(m0_b), 32'd0);
    check("m1_b", 32'(m1_b), 32'd0);
    check("slave bready", 32'(s_rdy), 32'd0);
    for (int n = 0; n < NUM_ROWS && !timed_out; n++) begin
      run_row(n);
    end
    $display("Rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/axi_pkg.sv
package axi_pkg;

  // Master-side ID, master tag and the slave-side ID built from both
  localparam int MID_BITS = 4;
  localparam int TAG_BITS = 4;
  localparam int SID_BITS = 8;

  // B channel response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } bresp_e;

  // Slave-side ID as laid out by the AW path
  // mid is the original master ID, tag names the master
  typedef struct packed {
    logic [MID_BITS-1:0] mid;
    logic [TAG_BITS-1:0] tag;
  } sid_fields_t;

  // One ID word, seen raw or split
  typedef union packed {
    logic [SID_BITS-1:0] raw;
    sid_fields_t         fields;
  } sid_u;

  // Slave-side B channel, 11 bits
  typedef struct packed {
    sid_u   id;
    bresp_e resp;
    logic   valid;
  } b_slv_t;

  // Master-side B channel, 7 bits
  typedef struct packed {
    logic [MID_BITS-1:0] id;
    bresp_e              resp;
    logic                valid;
  } b_mst_t;

endpackage

//--- verilog/b_channel_xbar.sv
`timescale 1ns/1ps

module b_channel_xbar (
  input  logic            clk,
  input  logic            rstn,
  // Slave ports
  input  axi_pkg::b_slv_t s0_b,
  input  axi_pkg::b_slv_t s1_b,
  input  axi_pkg::b_slv_t s2_b,
  output logic            s0_bready,
  output logic            s1_bready,
  output logic            s2_bready,
  // Master ports
  output axi_pkg::b_mst_t m0_b,
  output axi_pkg::b_mst_t m1_b,
  input  logic            m0_bready,
  input  logic            m1_bready
);

  import axi_pkg::*;

  // Locked response between arbiter and router
  b_slv_t arb_b;
  logic   arb_bready;

  b_resp_arbiter arb0 (
    .clk        (clk),
    .rstn       (rstn),
    .s0_b       (s0_b),
    .s1_b       (s1_b),
    .s2_b       (s2_b),
    .s0_bready  (s0_bready),
    .s1_bready  (s1_bready),
    .s2_bready  (s2_bready),
    .arb_b      (arb_b),
    .arb_bready (arb_bready)
  );

  b_resp_router rtr0 (
    .arb_b      (arb_b),
    .arb_bready (arb_bready),
    .m0_b       (m0_b),
    .m1_b       (m1_b),
    .m0_bready  (m0_bready),
    .m1_bready  (m1_bready)
  );

endmodule

//--- verilog/b_resp_arbiter.sv
`timescale 1ns/1ps

module b_resp_arbiter (
  input  logic            clk,
  input  logic            rstn,
  // Slave B channels
  input  axi_pkg::b_slv_t s0_b,
  input  axi_pkg::b_slv_t s1_b,
  input  axi_pkg::b_slv_t s2_b,
  output logic            s0_bready,
  output logic            s1_bready,
  output logic            s2_bready,
  // Towards the router
  output axi_pkg::b_slv_t arb_b,
  input  logic            arb_bready
);

  import axi_pkg::*;
  import xbar_pkg::*;

  lock_e  lock_q;
  lock_e  lock_d;
  logic   lock_enter;
  sid_u   sel_id;
  bresp_e sel_resp;
  sid_u   id_q;
  bresp_e resp_q;

  // Lock state
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_NO;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Fixed priority S0, S1, S2 when idle
  // A lock is held until the downstream side takes the response
  always_comb begin
    lock_d = lock_q;
    unique case (lock_q)
      LOCK_NO: begin
        if (s0_b.valid) begin
          lock_d = LOCK_S0;
        end else if (s1_b.valid) begin
          lock_d = LOCK_S1;
        end else if (s2_b.valid) begin
          lock_d = LOCK_S2;
        end
      end
      LOCK_S0, LOCK_S1, LOCK_S2: begin
        // Always back through idle, so one response per two cycles at most
        if (arb_bready) begin
          lock_d = LOCK_NO;
        end
      end
    endcase
  end

  assign lock_enter = (lock_q == LOCK_NO) && (lock_d != LOCK_NO);

  // Winning slave's ID and response
  always_comb begin
    sel_id.raw = '0;
    sel_resp   = OKAY;
    unique case (lock_d)
      LOCK_S0: begin
        sel_id   = s0_b.id;
        sel_resp = s0_b.resp;
      end
      LOCK_S1: begin
        sel_id   = s1_b.id;
        sel_resp = s1_b.resp;
      end
      LOCK_S2: begin
        sel_id   = s2_b.id;
        sel_resp = s2_b.resp;
      end
      LOCK_NO: begin
      end
    endcase
  end

  // Captured once on lock entry, held through any stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_q.raw <= '0;
      resp_q   <= OKAY;
    end else if (lock_enter) begin
      id_q.raw <= sel_id.raw;
      resp_q   <= sel_resp;
    end
  end

  assign arb_b.id    = id_q;
  assign arb_b.resp  = resp_q;
  assign arb_b.valid = (lock_q != LOCK_NO);

  // Only the locked slave sees the downstream ready
  always_comb begin
    s0_bready = 1'b0;
    s1_bready = 1'b0;
    s2_bready = 1'b0;
    unique case (lock_q)
      LOCK_S0: begin
        s0_bready = arb_bready;
      end
      LOCK_S1: begin
        s1_bready = arb_bready;
      end
      LOCK_S2: begin
        s2_bready = arb_bready;
      end
      LOCK_NO: begin
      end
    endcase
  end

endmodule

//--- verilog/b_resp_router.sv
`timescale 1ns/1ps

module b_resp_router (
  // From the arbiter
  input  axi_pkg::b_slv_t arb_b,
  output logic            arb_bready,
  // Master B channels
  output axi_pkg::b_mst_t m0_b,
  output axi_pkg::b_mst_t m1_b,
  input  logic            m0_bready,
  input  logic            m1_bready
);

  import axi_pkg::*;
  import xbar_pkg::*;

  sid_fields_t fields;
  master_e     dst;
  b_mst_t      mst_b;

  // Low nibble picks the master, high nibble is that master's own ID
  assign fields = arb_b.id.fields;
  assign dst    = decode_master(fields.tag);

  // Response as the master sees it, tag stripped
  assign mst_b.id    = fields.mid;
  assign mst_b.resp  = arb_b.resp;
  assign mst_b.valid = arb_b.valid;

  always_comb begin
    m0_b       = '0;
    m1_b       = '0;
    arb_bready = 1'b0;
    unique case (dst)
      MASTER_0: begin
        m0_b       = mst_b;
        arb_bready = m0_bready;
      end
      MASTER_1: begin
        m1_b       = mst_b;
        arb_bready = m1_bready;
      end
      MASTER_U: begin
        // Stray tag, accept and drop so the slave is not stuck
        arb_bready = 1'b1;
      end
    endcase
  end

endmodule

//--- verilog/xbar_pkg.sv
package xbar_pkg;

  // Arbiter lock, idle or one state per slave
  typedef enum logic [1:0] {
    LOCK_NO = 2'd0,
    LOCK_S0 = 2'd1,
    LOCK_S1 = 2'd2,
    LOCK_S2 = 2'd3
  } lock_e;

  // Response destination
  typedef enum logic [1:0] {
    MASTER_0 = 2'd0,
    MASTER_1 = 2'd1,
    MASTER_U = 2'd2
  } master_e;

  // Tags handed out on the write-address path
  localparam logic [axi_pkg::TAG_BITS-1:0] TAG_M0 = 0;
  localparam logic [axi_pkg::TAG_BITS-1:0] TAG_M1 = 1;

  // Any tag the AW path never issued goes nowhere
  function automatic master_e decode_master(
    input logic [axi_pkg::TAG_BITS-1:0] tag
  );
    master_e dst;
    case (tag)
      TAG_M0: begin
        dst = MASTER_0;
      end
      TAG_M1: begin
        dst = MASTER_1;
      end
      default: begin
        dst = MASTER_U;
      end
    endcase
    return dst;
  endfunction

endpackage
